// ==== sdmacPkg.sv ====
`default_nettype none

package sdmacPkg;

    // Data widths
    typedef logic [31:0] wordT;     // Memory bus and FIFO word
    typedef logic [7:0]  byteT;     // Peripheral port byte
    typedef logic [1:0]  regAddrT;  // CPU register select
    typedef logic [3:0]  fifoCntT;  // Holds 0..FIFO_DEPTH
    typedef logic [1:0]  byteIdxT;  // 0 is the most significant byte

    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    // Register map
    localparam regAddrT REG_CONTROL = 2'd0;  // [0] dmaEna [1] dirToMem [2] intEna
    localparam regAddrT REG_STATUS  = 2'd1;  // [0] empty [1] full [2] partial [3] irq
    localparam regAddrT REG_FLUSH   = 2'd2;  // Any write flushes and the data is ignored

    // Peripheral strobe width in clocks
    localparam int IO_PULSE_CYCLES = 3;

    // Words per bus tenure
    localparam int MAX_BURST = 4;

    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_REQUEST,
        BUS_CYCLE,
        BUS_RELEASE
    } busStateT;

    typedef enum logic [1:0] {
        PORT_IDLE,
        PORT_STROBE,
        PORT_RECOVER
    } portStateT;

endpackage

`default_nettype wire

// ==== sdmacRegs.sv ====
`timescale 1ns/1ns
`default_nettype none

module sdmacRegs import sdmacPkg::*; (
    input  wire     QnCPUCLK,
    input  wire     rstN_i,
    input  wire     regWr_i,
    input  wire     regRd_i,
    input  regAddrT regAddr_i,
    input  wordT    regWData_i,
    output wordT    regRData_o,
    output logic    regRdValid_o,
    input  wire     perIrq_i,
    input  wire     fifoEmpty_i,
    input  wire     fifoFull_i,
    input  wire     partialWord_i,
    output logic    dmaEna_o,
    output logic    dirToMem_o,
    output logic    flush_o,
    output logic    irq_o
);

    logic intEna;
    logic irqPend;    // Chip interrupt one clock behind the pin

    wire ctrlWr  = regWr_i && (regAddr_i == REG_CONTROL);
    wire flushWr = regWr_i && (regAddr_i == REG_FLUSH);

    // Control register and flush pulse
    always_ff @(posedge QnCPUCLK or negedge rstN_i) begin
        if (!rstN_i) begin
            dmaEna_o   <= 1'b0;
            dirToMem_o <= 1'b0;
            intEna     <= 1'b0;
            flush_o    <= 1'b0;
        end else begin
            flush_o <= flushWr;
            if (ctrlWr) begin
                dmaEna_o   <= regWData_i[0];
                dirToMem_o <= regWData_i[1];
                intEna     <= regWData_i[2];
            end
        end
    end

    always_ff @(posedge QnCPUCLK or negedge rstN_i) begin
        if (!rstN_i) begin
            irqPend      <= 1'b0;
            regRdValid_o <= 1'b0;
        end else begin
            irqPend      <= perIrq_i;
            regRdValid_o <= regRd_i;
        end
    end

    // Read data lands together with regRdValid_o
    always_ff @(posedge QnCPUCLK) begin
        if (regRd_i) begin
            case (regAddr_i)
                REG_CONTROL: regRData_o <= {29'd0, intEna, dirToMem_o, dmaEna_o};
                REG_STATUS:  regRData_o <= {28'd0, irqPend, partialWord_i,
                                            fifoFull_i, fifoEmpty_i};
                default:     regRData_o <= '0;   // Flush reads as zero
            endcase
        end
    end

    assign irq_o = irqPend & intEna;

    // Back to back flush writes would collapse two commands into one long pulse
    flushSinglePulse: assert property (@(posedge QnCPUCLK) disable iff (!rstN_i)
        flush_o |=> !flush_o);

endmodule

`default_nettype wire

// ==== byteFifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module byteFifo import sdmacPkg::*; (
    input  wire     QnCPUCLK,
    input  wire     rstN_i,
    input  wire     dirToMem_i,
    input  wire     byteWr_i,
    input  byteT    byteIn_i,
    input  wire     byteRd_i,
    output byteT    byteOut_o,
    input  wire     wordWr_i,
    input  wordT    wordIn_i,
    input  wire     wordRd_i,
    output wordT    wordOut_o,
    input  wire     flush_i,
    output logic    fifoEmpty_o,
    output logic    fifoFull_o,
    output logic    partialWord_o
);

    wordT                  mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wrPtr;
    logic [FIFO_PTR_W-1:0] rdPtr;
    fifoCntT               count;
    byteIdxT               byteIdx;  // Shared by packer and unpacker
    wordT                  packReg;  // Bytes gathered toward memory
    wordT                  flushWord;
    wordT                  pushData;
    logic                  flushPush;
    logic                  pushEn;
    logic                  popEn;

    // Partial word only matters when packing toward memory
    assign flushPush = flush_i && dirToMem_i && (byteIdx != 2'd0);

    always_comb begin
        case (byteIdx)
            2'd1:    flushWord = {packReg[31:24], 24'h0};
            2'd2:    flushWord = {packReg[31:16], 16'h0};
            default: flushWord = {packReg[31:8], 8'h0};
        endcase
    end

    assign pushEn   = wordWr_i || (byteWr_i && byteIdx == 2'd3) || flushPush;
    assign popEn    = wordRd_i || (byteRd_i && byteIdx == 2'd3);
    assign pushData = wordWr_i ? wordIn_i :
                      byteWr_i ? {packReg[31:8], byteIn_i} : flushWord;

    // Storage
    always_ff @(posedge QnCPUCLK) begin
        if (pushEn)
            mem[wrPtr] <= pushData;
        if (byteWr_i)
            packReg[{~byteIdx, 3'b000} +: 8] <= byteIn_i;   // Big endian slot
    end

    always_ff @(posedge QnCPUCLK or negedge rstN_i) begin
        if (!rstN_i) begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            count   <= '0;
            byteIdx <= '0;
        end else begin
            if (pushEn)
                wrPtr <= wrPtr + 1'b1;
            if (popEn)
                rdPtr <= rdPtr + 1'b1;
            case ({pushEn, popEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (flushPush)
                byteIdx <= '0;
            else if (byteWr_i || byteRd_i)
                byteIdx <= byteIdx + 1'b1;   // Wraps after index 3
        end
    end

    assign wordOut_o     = mem[rdPtr];
    assign byteOut_o     = wordOut_o[{~byteIdx, 3'b000} +: 8];
    assign fifoEmpty_o   = (count == '0);
    assign fifoFull_o    = (count == fifoCntT'(FIFO_DEPTH));
    assign partialWord_o = (byteIdx != 2'd0);

    // Senders check the flags a few cycles ahead of their strobes
    noOverflow: assert property (@(posedge QnCPUCLK) disable iff (!rstN_i)
        pushEn && !popEn |-> !fifoFull_o);

    noUnderflow: assert property (@(posedge QnCPUCLK) disable iff (!rstN_i)
        popEn |-> !fifoEmpty_o);

    oneByteSide: assert property (@(posedge QnCPUCLK) disable iff (!rstN_i)
        !(byteWr_i && byteRd_i));

endmodule

`default_nettype wire

// ==== scsiPortSeq.sv ====
`timescale 1ns/1ns
`default_nettype none

module scsiPortSeq import sdmacPkg::*; (
    input  wire  QnCPUCLK,
    input  wire  rstN_i,
    input  wire  dmaEna_i,
    input  wire  dirToMem_i,
    input  wire  perReq_i,
    output logic perAck_o,
    output logic perRd_o,
    output logic perWr_o,
    input  byteT perRData_i,
    output byteT perWData_o,
    input  wire  fifoEmpty_i,
    input  wire  fifoFull_i,
    input  byteT byteOut_i,
    output logic byteWr_o,
    output byteT byteIn_o,
    output logic byteRd_o
);

    portStateT  state;
    logic [1:0] pulseCnt;
    logic       toMem;      // Direction held for the whole byte
    logic       canMove;

    // Room for a byte toward memory, or a byte ready for the chip
    assign canMove = dirToMem_i ? !fifoFull_i : !fifoEmpty_i;

    always_ff @(posedge QnCPUCLK or negedge rstN_i) begin
        if (!rstN_i) begin
            state    <= PORT_IDLE;
            pulseCnt <= '0;
            toMem    <= 1'b0;
            perAck_o <= 1'b0;
            perRd_o  <= 1'b0;
            perWr_o  <= 1'b0;
        end else begin
            case (state)
                PORT_IDLE: begin
                    if (dmaEna_i && perReq_i && canMove) begin
                        state    <= PORT_STROBE;
                        pulseCnt <= '0;
                        toMem    <= dirToMem_i;
                        perAck_o <= 1'b1;
                        perRd_o  <= dirToMem_i;    // Chip to memory reads the chip
                        perWr_o  <= !dirToMem_i;
                    end
                end
                PORT_STROBE: begin
                    pulseCnt <= pulseCnt + 2'd1;
                    if (pulseCnt == 2'(IO_PULSE_CYCLES - 1)) begin
                        state    <= PORT_RECOVER;
                        perAck_o <= 1'b0;
                        perRd_o  <= 1'b0;
                        perWr_o  <= 1'b0;
                    end
                end
                default: state <= PORT_IDLE;   // Recover lasts one clock
            endcase
        end
    end

    // Byte payloads
    always_ff @(posedge QnCPUCLK) begin
        if (state == PORT_IDLE)
            perWData_o <= byteOut_i;   // Held through the strobe
        if (state == PORT_STROBE && pulseCnt == 2'(IO_PULSE_CYCLES - 1))
            byteIn_o <= perRData_i;    // Sampled in last strobe clock
    end

    assign byteWr_o = (state == PORT_RECOVER) && toMem;
    assign byteRd_o = (state == PORT_RECOVER) && !toMem;

    rdWrExclusive: assert property (@(posedge QnCPUCLK) disable iff (!rstN_i)
        !(perRd_o && perWr_o));

endmodule

`default_nettype wire

// ==== busMasterSm.sv ====
`timescale 1ns/1ns
`default_nettype none

module busMasterSm import sdmacPkg::*; (
    input  wire  QnCPUCLK,
    input  wire  rstN_i,
    input  wire  dmaEna_i,
    input  wire  dirToMem_i,
    input  wire  fifoEmpty_i,
    input  wire  fifoFull_i,
    input  wordT wordOut_i,
    output logic wordRd_o,
    output logic wordWr_o,
    output wordT wordIn_o,
    output logic busReq_o,
    input  wire  busGrant_i,
    output logic own_o,
    output logic dmaEn_o,
    output logic memStrobe_o,
    output logic memRead_o,
    output wordT memWData_o,
    input  wire  memAck_i,
    input  wordT memRData_i
);

    busStateT   state;
    logic [2:0] burstCnt;   // Words acknowledged in this tenure
    logic       haveWork;
    logic       wordDone;

    assign haveWork = dmaEna_i && (dirToMem_i ? !fifoEmpty_i : !fifoFull_i);
    assign wordDone = (state == BUS_CYCLE) && memStrobe_o && memAck_i;

    always_ff @(posedge QnCPUCLK or negedge rstN_i) begin
        if (!rstN_i) begin
            state       <= BUS_IDLE;
            burstCnt    <= '0;
            busReq_o    <= 1'b0;
            own_o       <= 1'b0;
            memStrobe_o <= 1'b0;
            memRead_o   <= 1'b0;
        end else begin
            case (state)
                BUS_IDLE: begin
                    if (haveWork) begin
                        state    <= BUS_REQUEST;
                        busReq_o <= 1'b1;
                    end
                end
                BUS_REQUEST: begin
                    if (busGrant_i) begin
                        state    <= BUS_CYCLE;
                        own_o    <= 1'b1;
                        burstCnt <= '0;
                    end
                end
                BUS_CYCLE: begin
                    if (memStrobe_o) begin
                        // Memory latency stretches this phase
                        if (memAck_i) begin
                            memStrobe_o <= 1'b0;
                            burstCnt    <= burstCnt + 3'd1;
                        end
                    end else if (burstCnt == 3'(MAX_BURST) || !haveWork) begin
                        state    <= BUS_RELEASE;
                        own_o    <= 1'b0;
                        busReq_o <= 1'b0;
                    end else begin
                        memStrobe_o <= 1'b1;
                        memRead_o   <= !dirToMem_i;
                    end
                end
                default: state <= BUS_IDLE;   // One dead clock for the arbiter
            endcase
        end
    end

    // Head word is latched as the strobe starts
    always_ff @(posedge QnCPUCLK) begin
        if (state == BUS_CYCLE && !memStrobe_o)
            memWData_o <= wordOut_i;
    end

    assign wordRd_o = wordDone && dirToMem_i;
    assign wordWr_o = wordDone && !dirToMem_i;
    assign wordIn_o = memRData_i;
    assign dmaEn_o  = own_o;   // Address generator follows bus ownership

    strobeOnlyWhenOwner: assert property (@(posedge QnCPUCLK) disable iff (!rstN_i)
        memStrobe_o |-> own_o);

endmodule

`default_nettype wire

// ==== sdmacTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module sdmacTop import sdmacPkg::*; (
    input  wire     QnCPUCLK,
    input  wire     rstN_i,
    // CPU register port
    input  wire     regWr_i,
    input  wire     regRd_i,
    input  regAddrT regAddr_i,
    input  wordT    regWData_i,
    output wordT    regRData_o,
    output logic    regRdValid_o,
    output logic    irq_o,
    // Memory bus
    output logic    busReq_o,
    input  wire     busGrant_i,
    output logic    own_o,
    output logic    dmaEn_o,
    output logic    memStrobe_o,
    output logic    memRead_o,
    output wordT    memWData_o,
    input  wire     memAck_i,
    input  wordT    memRData_i,
    // SCSI chip port
    input  wire     perReq_i,
    input  wire     perIrq_i,
    output logic    perAck_o,
    output logic    perRd_o,
    output logic    perWr_o,
    input  byteT    perRData_i,
    output byteT    perWData_o
);

    logic dmaEna;
    logic dirToMem;
    logic flush;
    logic fifoEmpty;
    logic fifoFull;
    logic partialWord;
    logic byteWr;
    logic byteRd;
    byteT byteIn;
    byteT byteOut;
    logic wordWr;
    logic wordRd;
    wordT wordIn;
    wordT wordOut;

    sdmacRegs uRegs (
        .QnCPUCLK      (QnCPUCLK),
        .rstN_i        (rstN_i),
        .regWr_i       (regWr_i),
        .regRd_i       (regRd_i),
        .regAddr_i     (regAddr_i),
        .regWData_i    (regWData_i),
        .regRData_o    (regRData_o),
        .regRdValid_o  (regRdValid_o),
        .perIrq_i      (perIrq_i),
        .fifoEmpty_i   (fifoEmpty),
        .fifoFull_i    (fifoFull),
        .partialWord_i (partialWord),
        .dmaEna_o      (dmaEna),
        .dirToMem_o    (dirToMem),
        .flush_o       (flush),
        .irq_o         (irq_o)
    );

    byteFifo uFifo (
        .QnCPUCLK      (QnCPUCLK),
        .rstN_i        (rstN_i),
        .dirToMem_i    (dirToMem),
        .byteWr_i      (byteWr),
        .byteIn_i      (byteIn),
        .byteRd_i      (byteRd),
        .byteOut_o     (byteOut),
        .wordWr_i      (wordWr),
        .wordIn_i      (wordIn),
        .wordRd_i      (wordRd),
        .wordOut_o     (wordOut),
        .flush_i       (flush),
        .fifoEmpty_o   (fifoEmpty),
        .fifoFull_o    (fifoFull),
        .partialWord_o (partialWord)
    );

    scsiPortSeq uPortSeq (
        .QnCPUCLK    (QnCPUCLK),
        .rstN_i      (rstN_i),
        .dmaEna_i    (dmaEna),
        .dirToMem_i  (dirToMem),
        .perReq_i    (perReq_i),
        .perAck_o    (perAck_o),
        .perRd_o     (perRd_o),
        .perWr_o     (perWr_o),
        .perRData_i  (perRData_i),
        .perWData_o  (perWData_o),
        .fifoEmpty_i (fifoEmpty),
        .fifoFull_i  (fifoFull),
        .byteOut_i   (byteOut),
        .byteWr_o    (byteWr),
        .byteIn_o    (byteIn),
        .byteRd_o    (byteRd)
    );

    busMasterSm uBusMaster (
        .QnCPUCLK    (QnCPUCLK),
        .rstN_i      (rstN_i),
        .dmaEna_i    (dmaEna),
        .dirToMem_i  (dirToMem),
        .fifoEmpty_i (fifoEmpty),
        .fifoFull_i  (fifoFull),
        .wordOut_i   (wordOut),
        .wordRd_o    (wordRd),
        .wordWr_o    (wordWr),
        .wordIn_o    (wordIn),
        .busReq_o    (busReq_o),
        .busGrant_i  (busGrant_i),
        .own_o       (own_o),
        .dmaEn_o     (dmaEn_o),
        .memStrobe_o (memStrobe_o),
        .memRead_o   (memRead_o),
        .memWData_o  (memWData_o),
        .memAck_i    (memAck_i),
        .memRData_i  (memRData_i)
    );

endmodule

`default_nettype wire

// ==== tbSdmac.sv ====
`timescale 1ns/1ns
`default_nettype none

module tbSdmac import sdmacPkg::*; ();

    logic    QnCPUCLK;
    logic    rstN_i;
    logic    regWr_i;
    logic    regRd_i;
    regAddrT regAddr_i;
    wordT    regWData_i;
    wordT    regRData_o;
    logic    regRdValid_o;
    logic    irq_o;
    logic    busReq_o;
    logic    busGrant_i;
    logic    own_o;
    logic    dmaEn_o;
    logic    memStrobe_o;
    logic    memRead_o;
    wordT    memWData_o;
    logic    memAck_i;
    wordT    memRData_i;
    logic    perReq_i;
    logic    perIrq_i;
    logic    perAck_o;
    logic    perRd_o;
    logic    perWr_o;
    byteT    perRData_i;
    byteT    perWData_o;

    integer seed = 32'h6783;
    int     checkCount = 0;
    int     errorCount = 0;

    // Stimulus and captured traffic
    byteT   srcBytes [16];   // Bytes the SCSI model hands to the core
    wordT   memImage [16];   // Words the memory returns on reads
    byteT   rxBytes [$];     // Bytes seen on perWr_o pulses
    wordT   memWords [$];    // Words written to memory
    int     srcCount = 0;
    int     srcIdx = 0;
    int     rxExpect = 0;
    int     rdIdx = 0;
    int     ackWait = 0;
    int     grantWait = 0;
    int     ackLen = 0;      // Clocks of the current perAck_o pulse
    logic   prevRd = 1'b0;
    logic   prevWr = 1'b0;
    byteT   lastWrByte = '0;

    sdmacTop dut (
        .QnCPUCLK     (QnCPUCLK),
        .rstN_i       (rstN_i),
        .regWr_i      (regWr_i),
        .regRd_i      (regRd_i),
        .regAddr_i    (regAddr_i),
        .regWData_i   (regWData_i),
        .regRData_o   (regRData_o),
        .regRdValid_o (regRdValid_o),
        .irq_o        (irq_o),
        .busReq_o     (busReq_o),
        .busGrant_i   (busGrant_i),
        .own_o        (own_o),
        .dmaEn_o      (dmaEn_o),
        .memStrobe_o  (memStrobe_o),
        .memRead_o    (memRead_o),
        .memWData_o   (memWData_o),
        .memAck_i     (memAck_i),
        .memRData_i   (memRData_i),
        .perReq_i     (perReq_i),
        .perIrq_i     (perIrq_i),
        .perAck_o     (perAck_o),
        .perRd_o      (perRd_o),
        .perWr_o      (perWr_o),
        .perRData_i   (perRData_i),
        .perWData_o   (perWData_o)
    );

    initial begin
        QnCPUCLK = 1'b0;
        forever #20 QnCPUCLK = ~QnCPUCLK;
    end

    // Expected memory word k when the first nBytes source bytes were sent
    function automatic wordT expectWord(input int k, input int nBytes);
        wordT w;
        int   i;
        w = '0;
        for (i = 0; i < 4; i++) begin
            if (4 * k + i < nBytes)
                w[31 - 8 * i -: 8] = srcBytes[4 * k + i];   // First byte is the MSB
        end
        return w;
    endfunction

    // Expected byte k leaving the port as taken from the preloaded memory
    function automatic byteT expectByte(input int k);
        wordT w;
        w = memImage[k / 4];
        return w[31 - 8 * (k % 4) -: 8];
    endfunction

    task automatic reportFailure(input string msg);
        errorCount++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    task automatic checkEqual(input string what, input wordT got, input wordT exp);
        checkCount++;
        assert (got === exp)
        else begin
            errorCount++;
            $display("MISMATCH at %0t ns: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge QnCPUCLK);
            #5;
        end
    endtask

    task automatic applyReset();
        rstN_i   = 1'b0;
        srcCount = 0;
        srcIdx   = 0;
        rxExpect = 0;
        rdIdx    = 0;
        memWords.delete();
        rxBytes.delete();
        idleCycles(2);
        rstN_i = 1'b1;
    endtask

    task automatic cpuWrite(input regAddrT addr, input wordT data);
        regAddr_i  = addr;
        regWData_i = data;
        regWr_i    = 1'b1;
        idleCycles(1);
        regWr_i = 1'b0;
    endtask

    task automatic cpuRead(input regAddrT addr, output wordT data);
        int waitCnt;
        regAddr_i = addr;
        regRd_i   = 1'b1;
        idleCycles(1);
        regRd_i = 1'b0;
        waitCnt = 0;
        while (!regRdValid_o && waitCnt < 10) begin
            idleCycles(1);
            waitCnt++;
        end
        assert (regRdValid_o && waitCnt == 0)
        else reportFailure("register read data not valid one cycle after the strobe");
        data = regRData_o;
    endtask

    // Waits until memory, the SCSI source and the SCSI sink reach the given counts
    task automatic waitProgress(input int words, input int sent, input int rcvd);
        int waitCnt;
        waitCnt = 0;
        while ((memWords.size() < words || srcIdx < sent || rxBytes.size() < rcvd)
               && waitCnt < 2000) begin
            idleCycles(1);
            waitCnt++;
        end
        assert (memWords.size() >= words && srcIdx >= sent && rxBytes.size() >= rcvd)
        else reportFailure("timeout while waiting for the transfer to progress");
    endtask

    // Bus request must stay low for a while and not just between two tenures
    task automatic waitBusIdle(input string what);
        int lowRun;
        int waitCnt;
        lowRun  = 0;
        waitCnt = 0;
        while (lowRun < 8 && waitCnt < 400) begin
            idleCycles(1);
            lowRun = busReq_o ? 0 : lowRun + 1;
            waitCnt++;
        end
        assert (lowRun >= 8)
        else reportFailure($sformatf("bus request still active after %s", what));
    endtask

    // Arbiter grants 1 to 3 cycles after the request
    always @(posedge QnCPUCLK) begin : arbiter
        logic nextGrant;
        nextGrant = busGrant_i;
        if (!busReq_o) begin
            nextGrant = 1'b0;
            grantWait = 0;
        end else if (!busGrant_i) begin
            if (grantWait == 0)
                grantWait = 1 + ($unsigned($random(seed)) % 3);
            grantWait--;
            nextGrant = (grantWait == 0);
        end
        #5;
        busGrant_i = nextGrant;
    end

    // Memory answers each strobe after 1 to 4 cycles
    always @(posedge QnCPUCLK) begin : memModel
        logic ackNow;
        wordT rdWord;
        ackNow = 1'b0;
        rdWord = '0;
        if (memStrobe_o && !memAck_i) begin
            if (ackWait == 0)
                ackWait = 1 + ($unsigned($random(seed)) % 4);
            ackWait--;
            if (ackWait == 0) begin
                ackNow = 1'b1;
                if (memRead_o) begin
                    rdWord = memImage[rdIdx % 16];
                    rdIdx++;
                end else begin
                    memWords.push_back(memWData_o);
                end
            end
        end
        #5;
        memAck_i   = ackNow;
        memRData_i = rdWord;
    end

    // SCSI chip model that requests while it has bytes to give or room to take
    always @(posedge QnCPUCLK) begin : scsiModel
        logic nextReq;
        byteT nextData;
        assert (perAck_o === (perRd_o || perWr_o))
        else reportFailure("perAck_o and the read or write strobe are not high together");
        if (perAck_o) begin
            ackLen++;
        end else if (ackLen != 0) begin
            assert (ackLen == IO_PULSE_CYCLES)
            else reportFailure($sformatf("strobe lasted %0d cycles instead of %0d",
                                         ackLen, IO_PULSE_CYCLES));
            ackLen = 0;
        end
        if (perWr_o && prevWr) begin
            assert (perWData_o === lastWrByte)
            else reportFailure("write data changed during the write strobe");
        end
        if (perWr_o)
            lastWrByte = perWData_o;
        if (prevRd && !perRd_o)
            srcIdx++;                      // Core took the byte on this pulse
        if (prevWr && !perWr_o)
            rxBytes.push_back(lastWrByte);
        prevRd   = perRd_o;
        prevWr   = perWr_o;
        nextReq  = (srcIdx < srcCount) || (rxBytes.size() < rxExpect);
        nextData = srcBytes[srcIdx % 16];
        #5;
        perReq_i   = nextReq;
        perRData_i = nextData;
    end

    always @(posedge QnCPUCLK) begin : busMonitor
        if (rstN_i) begin
            assert (!memStrobe_o || own_o)
            else reportFailure("memory strobe seen without bus ownership");
            assert (!memStrobe_o || busGrant_i)
            else reportFailure("memory strobe seen without bus grant");
            assert (!own_o || dmaEn_o)
            else reportFailure("DMA enable low while the core owns the bus");
            assert (!own_o || busReq_o)
            else reportFailure("bus ownership held without a bus request");
        end
    end

    initial begin : mainSeq
        wordT rdData;
        int   i;
        rstN_i     = 1'b0;
        regWr_i    = 1'b0;
        regRd_i    = 1'b0;
        regAddr_i  = REG_CONTROL;
        regWData_i = '0;
        busGrant_i = 1'b0;
        memAck_i   = 1'b0;
        memRData_i = '0;
        perReq_i   = 1'b0;
        perIrq_i   = 1'b0;
        perRData_i = '0;
        applyReset();

        // Reset values and control readback
        checkEqual("control outputs after reset", {busReq_o, own_o, memStrobe_o, dmaEn_o,
                   perAck_o, perRd_o, perWr_o, irq_o, regRdValid_o}, '0);
        cpuRead(REG_STATUS, rdData);
        checkEqual("status after reset", rdData, 32'h1);
        cpuWrite(REG_CONTROL, 32'h6);
        cpuRead(REG_CONTROL, rdData);
        checkEqual("control readback", rdData, 32'h6);

        // Interrupt gating by intEna
        cpuWrite(REG_CONTROL, 32'h0);
        perIrq_i = 1'b1;
        idleCycles(2);
        checkEqual("irq while masked", irq_o, 1'b0);
        cpuRead(REG_STATUS, rdData);
        checkEqual("status irq bit while masked", rdData[3], 1'b1);
        cpuWrite(REG_CONTROL, 32'h4);
        checkEqual("irq when enabled", irq_o, 1'b1);
        perIrq_i = 1'b0;
        idleCycles(2);
        checkEqual("irq after chip release", irq_o, 1'b0);
        cpuRead(REG_STATUS, rdData);
        checkEqual("status irq bit after release", rdData[3], 1'b0);
        perIrq_i = 1'b1;
        idleCycles(1);
        checkEqual("irq raised again", irq_o, 1'b1);
        cpuWrite(REG_CONTROL, 32'h0);
        checkEqual("irq after disable", irq_o, 1'b0);
        perIrq_i = 1'b0;

        // 16 bytes toward memory
        applyReset();
        for (i = 0; i < 16; i++)
            srcBytes[i] = $random(seed);
        srcCount = 16;
        cpuWrite(REG_CONTROL, 32'h3);
        waitProgress(4, 16, 0);
        waitBusIdle("to-memory transfer");
        checkEqual("to-memory word count", memWords.size(), 4);
        for (i = 0; i < memWords.size() && i < 4; i++)
            checkEqual($sformatf("to-memory word %0d", i), memWords[i], expectWord(i, 16));

        // Six bytes, then a flush of the partial word
        applyReset();
        for (i = 0; i < 6; i++)
            srcBytes[i] = $random(seed);
        srcCount = 6;
        cpuWrite(REG_CONTROL, 32'h3);
        waitProgress(1, 6, 0);
        idleCycles(2);
        cpuRead(REG_STATUS, rdData);
        checkEqual("partialWord before flush", rdData[2], 1'b1);
        cpuWrite(REG_FLUSH, 32'h0);
        waitProgress(2, 6, 0);
        waitBusIdle("flush transfer");
        checkEqual("flush word count", memWords.size(), 2);
        for (i = 0; i < memWords.size() && i < 2; i++)
            checkEqual($sformatf("flush word %0d", i), memWords[i], expectWord(i, 6));
        cpuRead(REG_STATUS, rdData);
        checkEqual("partialWord after flush", rdData[2], 1'b0);

        // Four words out of memory toward the chip
        applyReset();
        for (i = 0; i < 16; i++)
            memImage[i] = $random(seed);
        rxExpect = 16;
        cpuWrite(REG_CONTROL, 32'h1);
        waitProgress(0, 0, 16);
        waitBusIdle("from-memory transfer");
        checkEqual("from-memory byte count", rxBytes.size(), 16);
        for (i = 0; i < rxBytes.size() && i < 16; i++)
            checkEqual($sformatf("from-memory byte %0d", i), rxBytes[i], expectByte(i));

        $display("Checks: %0d  Errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
sdmacPkg.sv
sdmacRegs.sv
byteFifo.sv
scsiPortSeq.sv
busMasterSm.sv
sdmacTop.sv
tbSdmac.sv
